/* source/sine_quarter_table.svh */
`ifndef SINE_QUARTER_TABLE_SVH
`define SINE_QUARTER_TABLE_SVH

// first quadrant of sine, sampled at bin centres so both ends mirror cleanly
localparam logic [WAVE_W-2:0] sine_quarter_table [2**QTR_ADDR_W] = '{
   11'd50,
   11'd151,
   11'd251,
   11'd350,
   11'd448,
   11'd546,
   11'd642,
   11'd737,
   11'd830,
   11'd920,
   11'd1009,
   11'd1095,
   11'd1179,
   11'd1259,
   11'd1337,
   11'd1411,
   11'd1483,
   11'd1550,
   11'd1614,
   11'd1674,
   11'd1729,
   11'd1781,
   11'd1828,
   11'd1871,
   11'd1910,
   11'd1944,
   11'd1973,
   11'd1997,
   11'd2017,
   11'd2032,
   11'd2041,
   11'd2046
};

`endif

/* source/dds_lab_pkg.sv */
package dds_lab_pkg;

   ////////////////////
   // widths and timing
   ////////////////////

   localparam int PHASE_W = 32;
   localparam int WAVE_W = 12;
   localparam int LFSR_W = 5;
   localparam logic [LFSR_W-1:0] LFSR_SEED = 5'b00001;

   localparam int LFSR_TICK_CYCLES = 200;   // stands in for the 1 Hz divider
   localparam int LFSR_TICK_W = $clog2(LFSR_TICK_CYCLES);
   localparam int SAMPLE_DIVIDE = 70;       // clocks between scope captures
   localparam int SAMPLE_DIV_W = $clog2(SAMPLE_DIVIDE);

   localparam int NUM_KEYS = 17;

   // sine lookup, 2 quadrant bits above 5 table address bits
   localparam int QTR_ADDR_W = 5;
   localparam logic [PHASE_W-1:0] QUARTER_TURN = {2'b01, {(PHASE_W - 2){1'b0}}};

   // symmetric so that negating a square never overflows
   localparam logic signed [WAVE_W-1:0] WAVE_FULL_SCALE = WAVE_W'((1 << (WAVE_W - 1)) - 1);

   ////////////////////
   // mode encodings
   ////////////////////

   typedef enum logic [1:0]
   {
      WAVE_SINE   = 2'd0,
      WAVE_SAW    = 2'd1,
      WAVE_SQUARE = 2'd2,
      WAVE_COSINE = 2'd3
   } wave_sel_t;

   typedef enum logic [1:0]
   {
      MOD_NONE = 2'd0,
      MOD_ASK  = 2'd1,
      MOD_FSK  = 2'd2,
      MOD_BPSK = 2'd3
   } mod_sel_t;

   ////////////////////
   // keyboard
   ////////////////////

   // set 2 scan codes, arrows are the E0-prefixed codes with the prefix stripped
   localparam logic [7:0] key_code_table [NUM_KEYS] = '{
      8'h16, 8'h1E, 8'h26, 8'h25,   // 1 2 3 4
      8'h2E, 8'h36, 8'h3D, 8'h3E,   // 5 6 7 8
      8'h05, 8'h06,                 // F1 F2
      8'h31, 8'h3A,                 // N M
      8'h29,                        // space
      8'h6B, 8'h74, 8'h75, 8'h72    // left right up down
   };

   typedef logic [NUM_KEYS-1:0] key_held_t;

   typedef struct packed
   {
      logic [7:0] scan_code;
      logic       is_break;
   } kb_event_t;

   ////////////////////
   // scope stream
   ////////////////////

   typedef struct packed
   {
      logic signed [WAVE_W-1:0] raw;
      logic signed [WAVE_W-1:0] modulated;
      logic                     lfsr_bit;
      logic                     overrun;    // an earlier capture was lost
   } scope_sample_t;

endpackage

/* source/lfsr_bit_source.sv */
`timescale 1ns/1ps

module lfsr_bit_source
(
   input  logic                             CLK_25MHZ,
   input  logic                             reset_from_key,
   output logic [dds_lab_pkg::LFSR_W-1:0]   lfsr_value,
   output logic                             lfsr_bit
);
   import dds_lab_pkg::*;

   logic [LFSR_TICK_W-1:0] tick_count;
   logic                   tick;
   logic                   feedback;

   assign tick = (tick_count == LFSR_TICK_W'(LFSR_TICK_CYCLES - 1));

   // taps for x^5 + x^3 + 1, period 31
   assign feedback = lfsr_value[4] ^ lfsr_value[2];

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         tick_count <= '0;
         lfsr_value <= LFSR_SEED;
      end
      else
      begin
         if (tick)
            tick_count <= '0;
         else
            tick_count <= tick_count + 1'b1;

         if (tick)
            lfsr_value <= {lfsr_value[LFSR_W-2:0], feedback};   // shift left
      end
   end

   assign lfsr_bit = lfsr_value[0];   // modulating data bit

endmodule

/* source/dds_core.sv */
`timescale 1ns/1ps

module dds_core
(
   input  logic                                  CLK_25MHZ,
   input  logic                                  reset_from_key,
   input  logic [dds_lab_pkg::PHASE_W-1:0]       phase_inc,
   input  logic [dds_lab_pkg::PHASE_W-1:0]       fsk_phase_inc,
   input  dds_lab_pkg::wave_sel_t                wave_sel,
   input  dds_lab_pkg::mod_sel_t                 mod_sel,
   input  logic                                  data_bit,
   output logic signed [dds_lab_pkg::WAVE_W-1:0] wave
);
   import dds_lab_pkg::*;
   `include "sine_quarter_table.svh"

   logic [PHASE_W-1:0]       phase;
   logic [PHASE_W-1:0]       active_inc;
   logic [PHASE_W-1:0]       shape_phase;
   logic [1:0]               quadrant;
   logic [QTR_ADDR_W-1:0]    qtr_addr;
   logic [QTR_ADDR_W-1:0]    tab_addr;
   logic signed [WAVE_W-1:0] qtr_mag;
   logic signed [WAVE_W-1:0] shaped;
   logic signed [WAVE_W-1:0] keyed;

   ////////////////////
   // phase accumulator
   ////////////////////

   // FSK switches to the second tone while the bit is high
   assign active_inc = (mod_sel == MOD_FSK && data_bit) ? fsk_phase_inc : phase_inc;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase <= '0;
      else
         phase <= phase + active_inc;
   end

   ////////////////////
   // waveform shaping
   ////////////////////

   assign shape_phase = (wave_sel == WAVE_COSINE) ? phase + QUARTER_TURN : phase;
   assign quadrant    = shape_phase[PHASE_W-1 -: 2];
   assign qtr_addr    = shape_phase[PHASE_W-3 -: QTR_ADDR_W];
   assign tab_addr    = quadrant[0] ? ~qtr_addr : qtr_addr;   // falling quadrants mirror

   always_comb
   begin
      qtr_mag = $signed({1'b0, sine_quarter_table[tab_addr]});
      case (wave_sel)
         WAVE_SAW:    shaped = $signed(phase[PHASE_W-1 -: WAVE_W]);
         WAVE_SQUARE: shaped = phase[PHASE_W-1] ? -WAVE_FULL_SCALE : WAVE_FULL_SCALE;
         default:     shaped = quadrant[1] ? -qtr_mag : qtr_mag;   // sine, cosine
      endcase
   end

   ////////////////////
   // keying
   ////////////////////

   // ASK and BPSK only act on a zero bit
   always_comb
   begin
      keyed = shaped;
      if (!data_bit)
      begin
         case (mod_sel)
            MOD_ASK:  keyed = '0;
            MOD_BPSK: keyed = -shaped;
            default:  keyed = shaped;
         endcase
      end
   end

   always_ff @(posedge CLK_25MHZ)
      wave <= keyed;

endmodule

/* source/key_hold_tracker.sv */
`timescale 1ns/1ps

module key_hold_tracker
(
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   input  logic                   kb_valid,
   input  dds_lab_pkg::kb_event_t kb_event,
   output dds_lab_pkg::key_held_t key_held
);
   import dds_lab_pkg::*;

   key_held_t code_hit;

   // one-hot match of the scan code, all zero for codes we do not track
   always_comb
   begin
      for (int i = 0; i < NUM_KEYS; i++)
      begin
         code_hit[i] = (kb_event.scan_code == key_code_table[i]);
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         key_held <= '0;
      else if (kb_valid)
      begin
         if (kb_event.is_break)
            key_held <= key_held & ~code_hit;   // release
         else
            key_held <= key_held | code_hit;    // press
      end
   end

endmodule

/* source/scope_sampler.sv */
`timescale 1ns/1ps

module scope_sampler
(
   input  logic                                  CLK_25MHZ,
   input  logic                                  reset_from_key,
   input  logic signed [dds_lab_pkg::WAVE_W-1:0] raw_wave,
   input  logic signed [dds_lab_pkg::WAVE_W-1:0] mod_wave,
   input  logic                                  lfsr_bit,
   output logic                                  sample_valid,
   output dds_lab_pkg::scope_sample_t            sample,
   input  logic                                  sample_ready
);
   import dds_lab_pkg::*;

   logic [SAMPLE_DIV_W-1:0] div_count;
   logic                    fire;
   logic                    transfer;
   logic                    capture;
   logic                    overrun_pending;
   logic                    bit_q;

   assign fire     = (div_count == SAMPLE_DIV_W'(SAMPLE_DIVIDE - 1));
   assign transfer = sample_valid && sample_ready;
   assign capture  = fire && (!sample_valid || transfer);   // slot free or emptying now

   ////////////////////
   // control
   ////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         div_count       <= '0;
         sample_valid    <= 1'b0;
         overrun_pending <= 1'b0;
      end
      else
      begin
         if (fire)
            div_count <= '0;
         else
            div_count <= div_count + 1'b1;

         if (capture)
            sample_valid <= 1'b1;
         else if (transfer)
            sample_valid <= 1'b0;

         if (capture)
            overrun_pending <= 1'b0;   // flag leaves with this sample
         else if (fire)
            overrun_pending <= 1'b1;   // held sample not taken, capture lost
      end
   end

   ////////////////////
   // payload
   ////////////////////

   // waves come out of a register, so the bit is delayed one clock to match
   always_ff @(posedge CLK_25MHZ)
   begin
      bit_q <= lfsr_bit;
      if (capture)
      begin
         sample.raw       <= raw_wave;
         sample.modulated <= mod_wave;
         sample.lfsr_bit  <= bit_q;
         sample.overrun   <= overrun_pending;
      end
   end

endmodule

/* source/dds_lab_top.sv */
`timescale 1ns/1ps

module dds_lab_top
(
   input  logic                              CLK_25MHZ,
   input  logic                              reset_from_key,
   input  logic [dds_lab_pkg::PHASE_W-1:0]   phase_inc,
   input  logic [dds_lab_pkg::PHASE_W-1:0]   fsk_phase_inc,
   input  dds_lab_pkg::wave_sel_t            raw_sel,
   input  dds_lab_pkg::wave_sel_t            carrier_sel,
   input  dds_lab_pkg::mod_sel_t             mod_sel,
   input  logic                              kb_valid,
   input  dds_lab_pkg::kb_event_t            kb_event,
   input  logic                              sample_ready,
   output logic                              sample_valid,
   output dds_lab_pkg::scope_sample_t        sample,
   output dds_lab_pkg::key_held_t            key_held,
   output logic [dds_lab_pkg::LFSR_W-1:0]    lfsr_value
);
   import dds_lab_pkg::*;

   logic                     lfsr_bit;
   logic signed [WAVE_W-1:0] raw_wave;
   logic signed [WAVE_W-1:0] mod_wave;

   lfsr_bit_source lfsr_src
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_value     (lfsr_value),
      .lfsr_bit       (lfsr_bit)
   );

   ////////////////////
   // two DDS channels
   ////////////////////

   dds_core raw_dds   // never modulated
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .fsk_phase_inc  ('0),
      .wave_sel       (raw_sel),
      .mod_sel        (MOD_NONE),
      .data_bit       (1'b0),
      .wave           (raw_wave)
   );

   dds_core mod_dds
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .fsk_phase_inc  (fsk_phase_inc),
      .wave_sel       (carrier_sel),
      .mod_sel        (mod_sel),
      .data_bit       (lfsr_bit),
      .wave           (mod_wave)
   );

   scope_sampler sampler
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .raw_wave       (raw_wave),
      .mod_wave       (mod_wave),
      .lfsr_bit       (lfsr_bit),
      .sample_valid   (sample_valid),
      .sample         (sample),
      .sample_ready   (sample_ready)
   );

   key_hold_tracker keys
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .kb_valid       (kb_valid),
      .kb_event       (kb_event),
      .key_held       (key_held)
   );

endmodule

/* sim/dds_lab_chk.sv */
`timescale 1ns/1ps

module dds_lab_chk
(
   input logic                              CLK_25MHZ,
   input logic                              reset_from_key,
   input logic                              sample_valid,
   input logic                              sample_ready,
   input dds_lab_pkg::scope_sample_t        sample,
   input dds_lab_pkg::key_held_t            key_held,
   input logic [dds_lab_pkg::LFSR_W-1:0]    lfsr_value
);

   // a stalled beat stays put
   assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
                    sample_valid && !sample_ready |=> sample_valid && $stable(sample))
      else $error("scope sample changed or dropped before transfer");

   assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
                    lfsr_value != '0)
      else $error("lfsr reached the all-zero state");

   assert property (@(posedge CLK_25MHZ)
                    reset_from_key |=> key_held == '0 && !sample_valid)
      else $error("state not cleared after reset");

endmodule

bind dds_lab_top dds_lab_chk chk
(
   .CLK_25MHZ      (CLK_25MHZ),
   .reset_from_key (reset_from_key),
   .sample_valid   (sample_valid),
   .sample_ready   (sample_ready),
   .sample         (sample),
   .key_held       (key_held),
   .lfsr_value     (lfsr_value)
);

/* sim/tb_dds_lab.sv */
`timescale 1ns/1ps

module tb_dds_lab;
   import dds_lab_pkg::*;

   localparam int CLK_PERIOD = 40;
   // rough cycle budget of the tests in run order
   localparam int TEST_CYCLES = 12 * SAMPLE_DIVIDE + 33 * LFSR_TICK_CYCLES
                                + 90 * SAMPLE_DIVIDE + 200 + 10 * SAMPLE_DIVIDE;
   localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

   logic               CLK_25MHZ;
   logic               reset_from_key;
   logic [PHASE_W-1:0] phase_inc;
   logic [PHASE_W-1:0] fsk_phase_inc;
   wave_sel_t          raw_sel;
   wave_sel_t          carrier_sel;
   mod_sel_t           mod_sel;
   logic               kb_valid;
   kb_event_t          kb_event;
   logic               sample_ready;
   logic               sample_valid;
   scope_sample_t      sample;
   key_held_t          key_held;
   logic [LFSR_W-1:0]  lfsr_value;

   int          err_count = 0;
   int          tests_ok = 0;
   int          tests_bad = 0;
   logic [31:0] rng = 32'h66b49db9;

   dds_lab_top DUT
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .fsk_phase_inc  (fsk_phase_inc),
      .raw_sel        (raw_sel),
      .carrier_sel    (carrier_sel),
      .mod_sel        (mod_sel),
      .kb_valid       (kb_valid),
      .kb_event       (kb_event),
      .sample_ready   (sample_ready),
      .sample_valid   (sample_valid),
      .sample         (sample),
      .key_held       (key_held),
      .lfsr_value     (lfsr_value)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #(CLK_PERIOD / 2) CLK_25MHZ = ~CLK_25MHZ;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired at %0t, the tests did not finish in time", $time);
      $display(">>> FAIL");
      $finish;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] v;
      v = x;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   function automatic logic [LFSR_W-1:0] lfsr_next(input logic [LFSR_W-1:0] v);
      return {v[3:0], v[4] ^ v[2]};   // shift left with feedback from bits 4 and 2
   endfunction

   ////////////////////
   // helpers
   ////////////////////

   task automatic apply_reset();
      @(posedge CLK_25MHZ);
      reset_from_key <= 1'b1;
      repeat (4) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;
   endtask

   task automatic set_mode(input wave_sel_t rs, input wave_sel_t cs, input mod_sel_t ms,
                           input logic [PHASE_W-1:0] inc, input logic [PHASE_W-1:0] finc);
      @(posedge CLK_25MHZ);
      raw_sel       <= rs;
      carrier_sel   <= cs;
      mod_sel       <= ms;
      phase_inc     <= inc;
      fsk_phase_inc <= finc;
   endtask

   // waits for a valid beat, reads it mid-cycle, lets it transfer on the next edge
   task automatic take_sample(output scope_sample_t s);
      int waited;
      waited = 0;
      s = '0;
      @(negedge CLK_25MHZ);
      while (!sample_valid && waited < 4 * SAMPLE_DIVIDE)
      begin
         @(negedge CLK_25MHZ);
         waited++;
      end
      if (!sample_valid)
      begin
         $display("no scope sample arrived by %0t", $time);
         err_count++;
      end
      else
         s = sample;
      @(posedge CLK_25MHZ);
   endtask

   task automatic report(input string name, input int errs_before);
      if (err_count == errs_before)
      begin
         tests_ok++;
         $display("test %s: ok", name);
      end
      else
      begin
         tests_bad++;
         $display("test %s: %0d errors", name, err_count - errs_before);
      end
   endtask

   ////////////////////
   // tests
   ////////////////////

   task automatic test_sawtooth();
      int            e0;
      logic [31:0]   inc;
      logic [31:0]   prod;
      logic [11:0]   step;
      logic [11:0]   diff;
      scope_sample_t prev;
      scope_sample_t cur;
      e0 = err_count;
      rng = xorshift(rng);
      inc = {rng[11:0] | 12'h001, 20'h0};   // nonzero multiple of 2^20
      prod = inc * 32'(SAMPLE_DIVIDE);
      step = prod[31:20];
      set_mode(WAVE_SAW, WAVE_SAW, MOD_NONE, inc, '0);
      take_sample(prev);   // flush the settling captures
      take_sample(prev);
      for (int i = 0; i < 8; i++)
      begin
         take_sample(cur);
         diff = cur.raw - prev.raw;
         if (diff !== step)
         begin
            $display("mismatch at %0t: sawtooth step %h, expected %h", $time, diff, step);
            err_count++;
         end
         prev = cur;
      end
      report("sawtooth", e0);
   endtask

   task automatic test_lfsr();
      int                e0;
      int                waited;
      logic [LFSR_W-1:0] model;
      logic [LFSR_W-1:0] last;
      e0 = err_count;
      apply_reset();
      @(negedge CLK_25MHZ);
      model = LFSR_SEED;
      if (lfsr_value !== model)
      begin
         $display("mismatch at %0t: lfsr after reset %b, expected %b", $time, lfsr_value, model);
         err_count++;
      end
      for (int n = 0; n < 31; n++)
      begin
         last = lfsr_value;
         waited = 0;
         while (lfsr_value === last && waited < 2 * LFSR_TICK_CYCLES)
         begin
            @(negedge CLK_25MHZ);
            waited++;
         end
         model = lfsr_next(model);
         if (lfsr_value !== model)
         begin
            $display("mismatch at %0t: lfsr step %0d is %b, expected %b",
                     $time, n, lfsr_value, model);
            err_count++;
         end
      end
      if (lfsr_value !== LFSR_SEED)
      begin
         $display("mismatch at %0t: lfsr after 31 steps is %b, expected the seed %b",
                  $time, lfsr_value, LFSR_SEED);
         err_count++;
      end
      report("lfsr", e0);
   endtask

   // ASK and BPSK against the raw channel on the same waveform
   task automatic test_keying(input mod_sel_t ms, input wave_sel_t ws);
      int                       e0;
      int                       zeros;
      int                       ones;
      logic signed [WAVE_W-1:0] expect_mod;
      scope_sample_t            s;
      e0 = err_count;
      zeros = 0;
      ones = 0;
      set_mode(ws, ws, ms, 32'h0151_2345, 32'h0);
      take_sample(s);
      for (int i = 0; i < 24; i++)
      begin
         take_sample(s);
         if (s.lfsr_bit)
         begin
            ones++;
            expect_mod = s.raw;
         end
         else
         begin
            zeros++;
            expect_mod = (ms == MOD_ASK) ? '0 : -s.raw;
         end
         if (s.modulated !== expect_mod)
         begin
            $display("mismatch at %0t: modulated %0d, expected %0d (raw %0d, bit %b)",
                     $time, s.modulated, expect_mod, s.raw, s.lfsr_bit);
            err_count++;
         end
      end
      if (zeros == 0 || ones == 0)
      begin
         $display("keying test never saw both bit values");
         err_count++;
      end
      report(ms == MOD_ASK ? "ask" : "bpsk", e0);
   endtask

   task automatic test_fsk();
      int            e0;
      int            compared;
      scope_sample_t prev;
      scope_sample_t older;
      scope_sample_t cur;
      e0 = err_count;
      compared = 0;
      set_mode(WAVE_SAW, WAVE_SQUARE, MOD_FSK, 32'h0, 32'h0123_4567);
      take_sample(older);
      take_sample(prev);
      for (int i = 0; i < 40; i++)
      begin
         take_sample(cur);
         // phase is frozen once the bit has been low for a whole capture
         if (!cur.lfsr_bit && !prev.lfsr_bit && !older.lfsr_bit)
         begin
            compared++;
            if (cur.modulated !== prev.modulated)
            begin
               $display("mismatch at %0t: fsk sample moved from %0d to %0d with bit low",
                        $time, prev.modulated, cur.modulated);
               err_count++;
            end
         end
         older = prev;
         prev = cur;
      end
      if (compared == 0)
      begin
         $display("fsk test found no run of low bits to compare");
         err_count++;
      end
      report("fsk", e0);
   endtask

   task automatic test_keys();
      int          e0;
      key_held_t   model;
      logic [7:0]  code;
      logic        brk;
      e0 = err_count;
      model = '0;
      for (int n = 0; n < 60; n++)
      begin
         rng = xorshift(rng);
         code = rng[0] ? key_code_table[rng[12:8] % NUM_KEYS] : rng[23:16];
         brk = rng[4] & rng[5];   // more makes than breaks
         for (int i = 0; i < NUM_KEYS; i++)
         begin
            if (key_code_table[i] == code)
               model[i] = !brk;
         end
         @(posedge CLK_25MHZ);
         kb_valid           <= 1'b1;
         kb_event.scan_code <= code;
         kb_event.is_break  <= brk;
         @(posedge CLK_25MHZ);
         kb_valid <= 1'b0;
         @(negedge CLK_25MHZ);
         if (key_held !== model)
         begin
            $display("mismatch at %0t: key_held %h, expected %h after code %h",
                     $time, key_held, model, code);
            err_count++;
         end
      end
      report("keys", e0);
   endtask

   task automatic test_backpressure();
      int            e0;
      int            waited;
      scope_sample_t held;
      scope_sample_t s;
      e0 = err_count;
      waited = 0;
      @(posedge CLK_25MHZ);
      sample_ready <= 1'b0;
      @(negedge CLK_25MHZ);
      while (!sample_valid && waited < 4 * SAMPLE_DIVIDE)
      begin
         @(negedge CLK_25MHZ);
         waited++;
      end
      held = sample;
      for (int i = 0; i < 4 * SAMPLE_DIVIDE; i++)
      begin
         @(negedge CLK_25MHZ);
         if (!sample_valid || sample !== held)
         begin
            $display("mismatch at %0t: held sample changed under back-pressure", $time);
            err_count++;
         end
      end
      @(posedge CLK_25MHZ);
      sample_ready <= 1'b1;
      take_sample(s);
      if (s !== held)
      begin
         $display("mismatch at %0t: released sample differs from the held one", $time);
         err_count++;
      end
      take_sample(s);
      if (!s.overrun)
      begin
         $display("mismatch at %0t: overrun clear after dropped captures", $time);
         err_count++;
      end
      take_sample(s);
      if (s.overrun)
      begin
         $display("mismatch at %0t: overrun still set on the following sample", $time);
         err_count++;
      end
      report("backpressure", e0);
   endtask

   initial
   begin
      reset_from_key = 1'b1;
      phase_inc      = '0;
      fsk_phase_inc  = '0;
      raw_sel        = WAVE_SINE;
      carrier_sel    = WAVE_SINE;
      mod_sel        = MOD_NONE;
      kb_valid       = 1'b0;
      kb_event       = '0;
      sample_ready   = 1'b1;
      apply_reset();

      test_sawtooth();
      test_lfsr();
      test_keying(MOD_ASK, WAVE_SINE);
      test_keying(MOD_BPSK, WAVE_COSINE);
      test_fsk();   // last wave test since it splits the two phases
      test_keys();
      test_backpressure();

      $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, err_count);
      if (err_count == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

/* compile.f */
+incdir+source
source/dds_lab_pkg.sv
source/lfsr_bit_source.sv
source/dds_core.sv
source/key_hold_tracker.sv
source/scope_sampler.sv
source/dds_lab_top.sv
sim/dds_lab_chk.sv
sim/tb_dds_lab.sv

/* Makefile */
TOP := tb_dds_lab
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir $(LOG)
